// File: common/ascon_ctrl_pkg.sv
// shared constants, types and state encodings of the masked ascon-128 controller
// imported by wildcard into every controller module and the testbench
package ascon_ctrl_pkg;

    // ==================================================
    // datapath geometry
    // ==================================================
    localparam int par                = 1;   // bits per cycle in a masked round
    localparam int shares             = 2;   // d+1 mask shares
    localparam int word_size          = 64;  // ascon lane width
    localparam int block_bytes        = 2 * word_size / 8;  // rate of ascon-128
    localparam int rounds_full        = 12;
    localparam int rounds_plain_start = 4;   // p^8 runs rounds 4..11

    // shift cycles of one masked round, the extra one is the shift-last state
    function automatic int masked_shift_cnt(int p);
        return (word_size + p - 1) / p + 1;
    endfunction

    function automatic int plain_shift_cnt(int p, int s);
        return word_size / (p * s) + 1;  // all shares move together
    endfunction

    localparam int masked_shifts = masked_shift_cnt(par);
    localparam int plain_shifts  = plain_shift_cnt(par, shares);

    typedef logic [$clog2(masked_shifts + 1)-1:0] bit_cnt_t;
    typedef logic [3:0]                           round_t;
    typedef logic [$clog2(block_bytes):0]         vbytes_t;  // 0..block_bytes

    // ==================================================
    // controller states and phases
    // ==================================================
    typedef enum logic [4:0] {
        st_idle, st_init_load,
        st_init_shift, st_init_shift_last, st_init_diffuse, st_init_diffuse_last,
        st_absorb_ad, st_ad_shift, st_ad_shift_last, st_ad_diffuse, st_ad_diffuse_last,
        st_absorb_msg, st_msg_shift, st_msg_shift_last, st_msg_diffuse, st_msg_diffuse_last,
        st_final_shift, st_final_shift_last, st_final_diffuse,
        st_squeeze_tag, st_done
    } ctrl_state_t;

    typedef enum logic [1:0] {ph_init, ph_assoc, ph_msg, ph_final} phase_t;

endpackage

// File: common/ctrl_ifs.sv
// bundles between the controller blocks
// round_if carries timer commands and status, block_if the intake decisions

interface round_if import ascon_ctrl_pkg::*; ();
    logic   count_shift;  // shift cycle in progress
    logic   clear_round;  // force round number to 0
    logic   step_round;   // diffuse cycle closes a round
    phase_t phase;        // selects shift limit and wrap value
    logic   shift_last;   // next cycle is the shift-last cycle
    logic   round_last;   // round 11
    logic   round_first;  // first round of the running permutation
    round_t round;

    modport timer (
        input  count_shift, clear_round, step_round, phase,
        output shift_last, round_last, round_first, round
    );
    modport sequencer (
        output count_shift, clear_round, step_round, phase,
        input  shift_last, round_last
    );
endinterface

interface block_if;
    logic accept;         // block or owed padding block taken this cycle
    logic in_msg;         // message phase
    logic pad_now;        // taken block gets padding appended
    logic extra_pending;  // padding-only block owed
    logic last_seen;      // final block of this phase absorbed
    logic final_msg;      // taken block closes the message

    modport intake    (input accept, in_msg, output pad_now, extra_pending, last_seen, final_msg);
    modport sequencer (output accept, in_msg, input extra_pending, last_seen, final_msg);
    modport monitor   (input accept, pad_now, extra_pending, last_seen, final_msg);
endinterface

// File: design/block_intake.sv
// input side of the controller
// classifies each accepted block and keeps the padding and last-block flags
module block_intake import ascon_ctrl_pkg::*; (
    input  logic    clk,
    input  logic    reset_n,
    input  logic    last_block,   // last associated-data block
    input  vbytes_t valid_bytes,
    input  logic    eot,          // last message block
    block_if.intake blk
);

    logic blk_last;   // current block ends its phase
    logic blk_full;
    logic in_msg_q;

    assign blk_last = blk.in_msg ? eot : last_block;
    assign blk_full = (valid_bytes >= vbytes_t'(block_bytes));

    // an owed padding block is all padding, a short final block is padded in place
    assign blk.pad_now   = blk.extra_pending || (blk_last && !blk_full);
    assign blk.final_msg = blk.in_msg && blk.pad_now;  // no permutation follows

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            blk.extra_pending <= 1'b0;
            blk.last_seen     <= 1'b0;
            in_msg_q          <= 1'b0;
        end else begin
            in_msg_q <= blk.in_msg;

            if (blk.accept) begin
                if (blk.extra_pending)
                    blk.extra_pending <= 1'b0;           // padding block consumed
                else if (blk_last && blk_full)
                    blk.extra_pending <= 1'b1;           // full final block owes one
            end

            if (blk.accept && blk_last && !blk.extra_pending)
                blk.last_seen <= 1'b1;
            else if (blk.in_msg != in_msg_q)
                blk.last_seen <= 1'b0;                   // new phase starts clean
        end
    end

endmodule

// File: sequencer/round_timer.sv
// bit-shift and round counters of the permutation
// limits follow the phase given by the sequencer, status goes back to it
module round_timer import ascon_ctrl_pkg::*; #(
    parameter int par    = ascon_ctrl_pkg::par,
    parameter int shares = ascon_ctrl_pkg::shares
) (
    input  logic    clk,
    input  logic    reset_n,
    round_if.timer  rnd
);

    localparam bit_cnt_t masked_lim = bit_cnt_t'(masked_shift_cnt(par));
    localparam bit_cnt_t plain_lim  = bit_cnt_t'(plain_shift_cnt(par, shares));

    bit_cnt_t shift_cnt;
    bit_cnt_t shift_lim;
    logic     masked;
    round_t   wrap_val;

    assign masked    = (rnd.phase == ph_init) || (rnd.phase == ph_final);
    assign shift_lim = masked ? masked_lim : plain_lim;
    // after init the next permutation is a plain p^8, after final a new p^12
    assign wrap_val  = (rnd.phase == ph_final) ? '0 : round_t'(rounds_plain_start);

    assign rnd.shift_last  = (shift_cnt == shift_lim - bit_cnt_t'(2));
    assign rnd.round_last  = (rnd.round == round_t'(rounds_full - 1));
    assign rnd.round_first = masked ? (rnd.round == '0)
                                    : (rnd.round == round_t'(rounds_plain_start));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            shift_cnt <= '0;
            rnd.round <= '0;
        end else begin
            if (rnd.count_shift) begin
                if (shift_cnt == shift_lim - bit_cnt_t'(1))
                    shift_cnt <= '0;                     // end of shift-last cycle
                else
                    shift_cnt <= shift_cnt + bit_cnt_t'(1);
            end

            if (rnd.clear_round)
                rnd.round <= '0;
            else if (rnd.step_round)
                rnd.round <= rnd.round_last ? wrap_val : rnd.round + round_t'(1);
        end
    end

endmodule

// File: sequencer/phase_sequencer.sv
// phase state machine of the controller
// walks init, assoc, msg and final and commands the round timer
module phase_sequencer import ascon_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  logic        start,
    input  logic        load_data,
    input  logic        valid_data_in,
    output ctrl_state_t state,
    round_if.sequencer  rnd,
    block_if.sequencer  blk
);

    ctrl_state_t next_state;
    logic        absorbing;

    assign absorbing  = (state == st_absorb_ad) || (state == st_absorb_msg);
    assign blk.accept = absorbing && (valid_data_in || blk.extra_pending);
    assign blk.in_msg = (rnd.phase == ph_msg);

    always_comb begin
        if (state inside {[st_init_load:st_init_diffuse_last]})
            rnd.phase = ph_init;
        else if (state inside {[st_absorb_ad:st_ad_diffuse_last]})
            rnd.phase = ph_assoc;
        else if (state inside {[st_absorb_msg:st_msg_diffuse_last]})
            rnd.phase = ph_msg;
        else
            rnd.phase = ph_final;  // idle and tag states wrap to round 0
    end

    // ==================================================
    // timer commands
    // ==================================================
    assign rnd.count_shift = state inside {st_init_shift, st_init_shift_last, st_ad_shift,
                                           st_ad_shift_last, st_msg_shift, st_msg_shift_last,
                                           st_final_shift, st_final_shift_last};
    assign rnd.step_round  = state inside {st_init_diffuse, st_init_diffuse_last,
                                           st_ad_diffuse, st_ad_diffuse_last, st_msg_diffuse,
                                           st_msg_diffuse_last, st_final_diffuse};
    assign rnd.clear_round = (state == st_init_load) || (blk.accept && blk.final_msg);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            state <= st_idle;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;  // hold, also under back-pressure
        case (state)
            st_idle:              if (load_data) next_state = st_init_load;
            st_init_load:         if (start) next_state = st_init_shift;
            st_init_shift:        if (rnd.shift_last) next_state = st_init_shift_last;
            st_init_shift_last:   next_state = rnd.round_last ? st_init_diffuse_last
                                                              : st_init_diffuse;
            st_init_diffuse:      next_state = st_init_shift;
            st_init_diffuse_last: next_state = st_absorb_ad;
            st_absorb_ad:         if (blk.accept) next_state = st_ad_shift;
            st_ad_shift:          if (rnd.shift_last) next_state = st_ad_shift_last;
            st_ad_shift_last:     next_state = rnd.round_last ? st_ad_diffuse_last
                                                              : st_ad_diffuse;
            st_ad_diffuse:        next_state = st_ad_shift;
            st_ad_diffuse_last:   next_state = (blk.last_seen && !blk.extra_pending)
                                               ? st_absorb_msg : st_absorb_ad;
            st_absorb_msg: begin
                if (blk.accept)
                    next_state = blk.final_msg ? st_final_shift : st_msg_shift;
            end
            st_msg_shift:         if (rnd.shift_last) next_state = st_msg_shift_last;
            st_msg_shift_last:    next_state = rnd.round_last ? st_msg_diffuse_last
                                                              : st_msg_diffuse;
            st_msg_diffuse:       next_state = st_msg_shift;
            st_msg_diffuse_last:  next_state = st_absorb_msg;
            st_final_shift:       if (rnd.shift_last) next_state = st_final_shift_last;
            st_final_shift_last:  next_state = st_final_diffuse;
            st_final_diffuse:     next_state = rnd.round_last ? st_squeeze_tag : st_final_shift;
            st_squeeze_tag:       next_state = st_done;
            st_done:              if (!start) next_state = st_idle;
            default:              next_state = st_idle;
        endcase
    end

endmodule

// File: design/strobe_decoder.sv
// output side of the controller, a mealy decode of state and intake decisions
// drives the state register, key register and datapath multiplexer selects
module strobe_decoder import ascon_ctrl_pkg::*; #(
    parameter int shares = ascon_ctrl_pkg::shares
) (
    input  ctrl_state_t       state,
    input  logic              valid_data_in,
    input  logic              round_last,
    input  logic              round_first,
    block_if.monitor          blk,
    output logic [shares-1:0] write_en,
    output logic              shift_en,
    output logic              shift_type,        // 1 = par bits, 0 = par*shares bits
    output logic              last_cycle,
    output logic              key_load,
    output logic              sel_init_load,
    output logic              sel_first_round,   // round constant of the first round
    output logic              sel_masked_round,
    output logic              sel_padding,
    output logic              sel_xor_key,
    output logic              sel_absorb_data,
    output logic              sel_x3_key,
    output logic              sel_x4_key,
    output logic              ciphertext_valid,
    output logic              tag_valid,
    output logic              done,
    output logic              ready_for_data,
    output logic              read_data
);

    logic absorbing;
    logic masked_st;

    assign absorbing = (state == st_absorb_ad) || (state == st_absorb_msg);
    assign masked_st = state inside {[st_init_shift:st_init_diffuse_last],
                                     [st_final_shift:st_final_diffuse]};

    // ==================================================
    // state register strobes
    // ==================================================
    always_comb begin
        write_en = '0;
        if (state inside {st_init_diffuse, st_init_diffuse_last, st_final_diffuse})
            write_en = '1;                               // masked diffuse loads every share
        else if (state inside {st_init_load, st_ad_diffuse, st_ad_diffuse_last,
                               st_msg_diffuse, st_msg_diffuse_last} || blk.accept)
            write_en[0] = 1'b1;                          // parallel load of share 0
    end

    assign shift_en   = state inside {st_init_shift, st_init_shift_last, st_ad_shift,
                                      st_ad_shift_last, st_msg_shift, st_msg_shift_last,
                                      st_final_shift, st_final_shift_last};
    assign shift_type = shift_en && masked_st;
    assign last_cycle = state inside {st_init_shift_last, st_ad_shift_last,
                                      st_msg_shift_last, st_final_shift_last};
    assign key_load   = (state == st_init_load);

    // ==================================================
    // multiplexer selects
    // ==================================================
    assign sel_init_load    = key_load || (blk.accept && blk.final_msg);  // key for final
    assign sel_first_round  = round_first && (masked_st ||
                              state inside {[st_absorb_ad:st_ad_diffuse_last]});
    assign sel_masked_round = masked_st;
    assign sel_padding      = blk.accept && blk.pad_now;
    assign sel_xor_key      = (state == st_init_diffuse_last);
    assign sel_absorb_data  = blk.accept;
    assign sel_x3_key       = state inside {st_init_diffuse_last, st_final_shift_last};
    assign sel_x4_key       = sel_x3_key || ((state == st_ad_diffuse_last) &&
                              blk.last_seen && !blk.extra_pending);  // domain separation

    // ==================================================
    // handshake and status
    // ==================================================
    assign ciphertext_valid = (state == st_absorb_msg) && blk.accept && !blk.extra_pending;
    assign tag_valid        = (state == st_final_diffuse) && round_last;
    assign done             = (state == st_done);
    assign ready_for_data   = absorbing && !valid_data_in && !blk.extra_pending;
    assign read_data        = absorbing;

endmodule

// File: design/ascon_ctrl_top.sv
// top level of the masked ascon-128 sequencing controller
// connects intake, sequencer, round timer and strobe decoder
module ascon_ctrl_top import ascon_ctrl_pkg::*; #(
    parameter int par    = ascon_ctrl_pkg::par,
    parameter int shares = ascon_ctrl_pkg::shares
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              start,
    input  logic              load_data,
    input  logic              valid_data_in,
    input  logic              last_block,
    input  vbytes_t           valid_bytes,
    input  logic              eot,
    output logic [shares-1:0] write_en,
    output logic              shift_en,
    output logic              shift_type,
    output logic              last_cycle,
    output logic              key_load,
    output logic              sel_init_load,
    output logic              sel_first_round,
    output logic              sel_masked_round,
    output logic              sel_padding,
    output logic              sel_xor_key,
    output logic              sel_absorb_data,
    output logic              sel_x3_key,
    output logic              sel_x4_key,
    output logic              ciphertext_valid,
    output logic              tag_valid,
    output logic              done,
    output logic              ready_for_data,
    output logic              read_data,
    output round_t            round
);

    ctrl_state_t state;

    round_if rnd ();
    block_if blk ();

    assign round = rnd.round;

    block_intake u_intake (
        .clk, .reset_n, .last_block, .valid_bytes, .eot,
        .blk (blk.intake)
    );

    round_timer #(.par(par), .shares(shares)) u_timer (
        .clk, .reset_n,
        .rnd (rnd.timer)
    );

    phase_sequencer u_seq (
        .clk, .reset_n, .start, .load_data, .valid_data_in, .state,
        .rnd (rnd.sequencer),
        .blk (blk.sequencer)
    );

    strobe_decoder #(.shares(shares)) u_dec (
        .state, .valid_data_in,
        .round_last  (rnd.round_last),
        .round_first (rnd.round_first),
        .blk         (blk.monitor),
        .write_en, .shift_en, .shift_type, .last_cycle, .key_load,
        .sel_init_load, .sel_first_round, .sel_masked_round, .sel_padding,
        .sel_xor_key, .sel_absorb_data, .sel_x3_key, .sel_x4_key,
        .ciphertext_valid, .tag_valid, .done, .ready_for_data, .read_data
    );

endmodule

// File: tb/tb_ascon_ctrl.sv
// testbench of the masked ascon-128 sequencing controller
// runs random ad/message scenarios twice, without and with idle gaps on valid_data_in,
// and checks strobe counts, tag/done timing and the idle state against a reference model
module tb_ascon_ctrl import ascon_ctrl_pkg::*; ();

    typedef struct packed {
        int shifts;   // cycles with shift_en
        int ct;       // ciphertext_valid pulses
        int pads;     // sel_padding cycles
        int tags;     // tag_valid pulses
    } counts_t;

    // ceiling of the lane over par, plus the shift-last cycle
    localparam int masked_len  = word_size / par + ((word_size % par) != 0 ? 1 : 0) + 1;
    localparam int plain_len   = word_size / (par * shares) + 1;    // shift cycles of a plain round
    localparam int n_configs   = 6;                                  // each runs twice
    localparam int longest_run = 24 * (masked_len + 1) + 8 * 8 * (plain_len + 1) + 7 * 5 + 20;
    localparam int timeout_cycles = 2 * n_configs * longest_run + 100;

    logic              clk;
    logic              reset_n;
    logic              start;
    logic              load_data;
    logic              valid_data_in;
    logic              last_block;
    vbytes_t           valid_bytes;
    logic              eot;
    logic [shares-1:0] write_en;
    logic              shift_en, shift_type, last_cycle, key_load;
    logic              sel_init_load, sel_first_round, sel_masked_round, sel_padding;
    logic              sel_xor_key, sel_absorb_data, sel_x3_key, sel_x4_key;
    logic              ciphertext_valid, tag_valid, done, ready_for_data, read_data;
    round_t            round;

    int      seed = 32'h6003e491;
    int      err_cnt = 0;
    int      chk_cnt = 0;
    int      cyc = 0;                                    // free-running edge count
    int      shift_n, ct_n, pad_n, tag_n, tag_cyc, done_cyc;
    bit      done_seen;
    counts_t exp_counts;
    string   scen_name;
    event    scen_done;                                  // counts are final and ready for compare

    ascon_ctrl_top #(.par(par), .shares(shares)) dut0 (.*);

    always #10 clk = ~clk;

    // ==================================================
    // reference model and helpers
    // ==================================================
    function automatic counts_t expected_counts(int ad_n, int msg_n, bit ad_full, bit msg_full);
        counts_t c;
        int      perms;
        // a full final block owes one more padding block and so one more p^8
        perms    = ad_n + (ad_full ? 1 : 0) + msg_n - 1 + (msg_full ? 1 : 0);
        c.shifts = 24 * masked_len + 8 * plain_len * perms;
        c.ct     = msg_n;                                // padding blocks give no ciphertext
        c.pads   = 2;                                    // one padded block per phase
        c.tags   = 1;
        return c;
    endfunction

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic compare_int(input string name, input int exp, input int act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("Mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // every strobe and status output at its reset value
    task automatic expect_idle(input string tag);
        compare_int({tag, " write_en"}, 0, int'(write_en));
        compare_int({tag, " round"}, 0, int'(round));
        compare_bit({tag, " shift_en"}, 1'b0, shift_en);
        compare_bit({tag, " shift_type"}, 1'b0, shift_type);
        compare_bit({tag, " last_cycle"}, 1'b0, last_cycle);
        compare_bit({tag, " key_load"}, 1'b0, key_load);
        compare_bit({tag, " sel_init_load"}, 1'b0, sel_init_load);
        compare_bit({tag, " sel_first_round"}, 1'b0, sel_first_round);
        compare_bit({tag, " sel_masked_round"}, 1'b0, sel_masked_round);
        compare_bit({tag, " sel_padding"}, 1'b0, sel_padding);
        compare_bit({tag, " sel_xor_key"}, 1'b0, sel_xor_key);
        compare_bit({tag, " sel_absorb_data"}, 1'b0, sel_absorb_data);
        compare_bit({tag, " sel_x3_key"}, 1'b0, sel_x3_key);
        compare_bit({tag, " sel_x4_key"}, 1'b0, sel_x4_key);
        compare_bit({tag, " ciphertext_valid"}, 1'b0, ciphertext_valid);
        compare_bit({tag, " tag_valid"}, 1'b0, tag_valid);
        compare_bit({tag, " done"}, 1'b0, done);
        compare_bit({tag, " ready_for_data"}, 1'b0, ready_for_data);
        compare_bit({tag, " read_data"}, 1'b0, read_data);
    endtask

    task automatic clear_counts();
        shift_n   = 0;
        ct_n      = 0;
        pad_n     = 0;
        tag_n     = 0;
        tag_cyc   = 0;
        done_cyc  = 0;
        done_seen = 1'b0;
    endtask

    // drive block b where the ad blocks precede the message blocks
    task automatic drive_block(input int b, input int ad_n, input int msg_n,
                               input bit ad_full, input bit msg_full);
        bit is_msg;
        bit is_last;
        bit full;
        is_msg  = (b >= ad_n);
        is_last = is_msg ? (b == ad_n + msg_n - 1) : (b == ad_n - 1);
        full    = is_last ? (is_msg ? msg_full : ad_full) : 1'b1;
        valid_data_in <= 1'b1;
        last_block    <= !is_msg && is_last;
        eot           <= is_msg && is_last;
        valid_bytes   <= full ? vbytes_t'(block_bytes)
                              : vbytes_t'(1 + rand_below(block_bytes - 1));  // 1..15 bytes
    endtask

    task automatic run_scenario(input int idx, input int ad_n, input int msg_n,
                                input bit ad_full, input bit msg_full, input bit gaps);
        int sent;
        int gap_left;
        bit in_gap;
        int hold;
        @(posedge clk);
        sent      = 0;
        in_gap    = 1'b0;
        gap_left  = gaps ? rand_below(4) : 0;
        scen_name = $sformatf("scen%0d(ad=%0d msg=%0d gaps=%0d)", idx, ad_n, msg_n, gaps);
        exp_counts = expected_counts(ad_n, msg_n, ad_full, msg_full);
        clear_counts();
        load_data <= 1'b1;
        @(posedge clk);
        load_data <= 1'b0;
        start     <= 1'b1;
        while (sent < ad_n + msg_n) begin
            @(posedge clk);
            if (in_gap)
                compare_bit({scen_name, " ready_in_gap"}, 1'b1, ready_for_data);
            in_gap = 1'b0;
            if (valid_data_in && read_data) begin        // block taken on this edge
                sent++;
                valid_data_in <= 1'b0;
                gap_left = gaps ? rand_below(4) : 0;
            end else if (!valid_data_in && read_data && ready_for_data) begin
                if (gap_left > 0) begin
                    gap_left--;
                    in_gap = 1'b1;                       // hold back for one cycle
                end else begin
                    drive_block(sent, ad_n, msg_n, ad_full, msg_full);
                end
            end
        end
        do @(posedge clk); while (!done);
        hold = 1 + rand_below(3);
        repeat (hold) begin
            @(posedge clk);
            compare_bit({scen_name, " done_hold"}, 1'b1, done);
        end
        start       <= 1'b0;
        last_block  <= 1'b0;
        eot         <= 1'b0;
        valid_bytes <= '0;
        @(posedge clk);
        compare_bit({scen_name, " done_last"}, 1'b1, done);  // leaves done one cycle later
        @(posedge clk);
        expect_idle({scen_name, " after_done"});
        -> scen_done;
    endtask

    // ==================================================
    // monitor, compare and watchdog
    // ==================================================
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (shift_en)
            shift_n++;
        if (ciphertext_valid)
            ct_n++;
        if (sel_padding)
            pad_n++;
        if (tag_valid) begin
            tag_n++;
            tag_cyc = cyc;
        end
        if (done && !done_seen) begin
            done_seen = 1'b1;
            done_cyc  = cyc;
        end
    end

    initial begin : compare
        forever begin
            @(scen_done);
            compare_int({scen_name, " shift_en_cycles"}, exp_counts.shifts, shift_n);
            compare_int({scen_name, " ciphertext_valid"}, exp_counts.ct, ct_n);
            compare_int({scen_name, " sel_padding"}, exp_counts.pads, pad_n);
            compare_int({scen_name, " tag_valid"}, exp_counts.tags, tag_n);
            compare_int({scen_name, " tag_to_done"}, 2, done_cyc - tag_cyc);
        end
    end

    initial begin : watchdog
        while (cyc < timeout_cycles)
            @(posedge clk);
        $display("timeout: no end of run after %0d cycles, errors so far %0d", cyc, err_cnt);
        $display("Simulation failed");
        $finish;
    end

    // ==================================================
    // stimulus
    // ==================================================
    initial begin : stimulus
        int ad_n;
        int msg_n;
        bit ad_full;
        bit msg_full;
        clk           = 1'b0;
        reset_n       = 1'b0;
        start         = 1'b0;
        load_data     = 1'b0;
        valid_data_in = 1'b0;
        last_block    = 1'b0;
        valid_bytes   = '0;
        eot           = 1'b0;
        repeat (5) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);
        expect_idle("after_reset");
        for (int i = 0; i < n_configs; i++) begin
            ad_n     = 1 + rand_below(3);
            msg_n    = 1 + rand_below(4);
            ad_full  = rand_below(2) == 1;
            msg_full = rand_below(2) == 1;
            for (int g = 0; g < 2; g++)
                run_scenario(2 * i + g, ad_n, msg_n, ad_full, msg_full, g == 1);
        end
        @(posedge clk);
        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: verilog.f
common/ascon_ctrl_pkg.sv
common/ctrl_ifs.sv
design/block_intake.sv
sequencer/round_timer.sv
sequencer/phase_sequencer.sv
design/strobe_decoder.sv
design/ascon_ctrl_top.sv
tb/tb_ascon_ctrl.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tb_ascon_ctrl -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1
